//--- verilog/i2c_pkg.sv
`default_nettype none

package i2c_pkg;

    typedef logic [6:0]  dev_addr_t;          // 7-bit device address
    typedef logic [15:0] mem_addr_t;          // word address, high byte optional
    typedef logic [7:0]  byte_t;
    typedef logic [5:0]  bit_cnt_t;           // cycle count inside one op

    // ******************************
    // transaction phases
    typedef enum logic [2:0] {
        ph_idle,
        ph_dev_wr,
        ph_addr_hi,
        ph_addr_lo,
        ph_wr_data,
        ph_dev_rd,
        ph_rd_data,
        ph_stop
    } phase_t;

    // operations handled by the bit engine
    typedef enum logic [2:0] {
        op_start_byte,                        // start + byte + ack slot
        op_restart_byte,                      // repeated start + byte + ack slot
        op_tx_byte,
        op_rx_byte,                           // byte in, then nack
        op_stop
    } bus_op_t;

    // ******************************
    // timing, in dri_clk cycles
    localparam int op_len_start = 40;
    localparam int op_len_byte  = 36;
    localparam int op_len_stop  = 17;
    localparam int start_len    = 4;          // start condition slot
    localparam int bit_len      = 4;
    localparam int sda_chg_ofs  = 0;
    localparam int scl_rise_ofs = 1;
    localparam int scl_fall_ofs = 3;

    function automatic bit_cnt_t op_len(input bus_op_t kind);
        case (kind)
            op_start_byte,
            op_restart_byte: op_len = bit_cnt_t'(op_len_start);
            op_stop:         op_len = bit_cnt_t'(op_len_stop);
            default:         op_len = bit_cnt_t'(op_len_byte);
        endcase
    endfunction

endpackage

`default_nettype wire

//--- verilog/i2c_phase_seq.sv
`timescale 1ns/1ns
`default_nettype none

module i2c_phase_seq import i2c_pkg::*; #(
    parameter dev_addr_t SLAVE_ADDR = 7'h10
) (
    input  logic      dri_clk,
    input  logic      rst_n,

    input  logic      i2c_exec,
    input  logic      bit_ctrl,
    input  logic      i2c_rh_wl,
    input  mem_addr_t i2c_addr,
    input  byte_t     i2c_data_w,

    input  logic      op_done,
    output logic      op_go,
    output bus_op_t   op_kind,
    output byte_t     op_byte,

    output logic      i2c_done
);

    phase_t    phase;
    phase_t    next_ph;
    logic      rd_q;                          // 1: read transaction
    logic      ctrl_q;                        // 1: 16-bit word address
    mem_addr_t addr_q;
    byte_t     data_q;
    bus_op_t   nxt_kind;
    byte_t     nxt_byte;
    logic      ph_change;

    // ******************************
    // next phase
    always_comb begin
        next_ph = phase;
        case (phase)
            ph_idle:    if (i2c_exec) next_ph = ph_dev_wr;
            ph_dev_wr:  if (op_done) next_ph = ctrl_q ? ph_addr_hi : ph_addr_lo;
            ph_addr_hi: if (op_done) next_ph = ph_addr_lo;
            ph_addr_lo: if (op_done) next_ph = rd_q ? ph_dev_rd : ph_wr_data;
            ph_wr_data: if (op_done) next_ph = ph_stop;
            ph_dev_rd:  if (op_done) next_ph = ph_rd_data;
            ph_rd_data: if (op_done) next_ph = ph_stop;
            ph_stop:    if (op_done) next_ph = ph_idle;
            default:    next_ph = ph_idle;
        endcase
    end

    assign ph_change = (next_ph != phase);

    // operation issued on entry to each phase
    always_comb begin
        nxt_kind = op_tx_byte;
        nxt_byte = 8'hff;
        case (next_ph)
            ph_dev_wr: begin
                nxt_kind = op_start_byte;
                nxt_byte = {SLAVE_ADDR, 1'b0};   // write bit
            end
            ph_addr_hi: nxt_byte = addr_q[15:8];
            ph_addr_lo: nxt_byte = addr_q[7:0];
            ph_wr_data: nxt_byte = data_q;
            ph_dev_rd: begin
                nxt_kind = op_restart_byte;
                nxt_byte = {SLAVE_ADDR, 1'b1};   // read bit
            end
            ph_rd_data: nxt_kind = op_rx_byte;
            ph_stop:    nxt_kind = op_stop;
            default: ;
        endcase
    end

    // ******************************
    // control state
    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            phase    <= ph_idle;
            op_go    <= 1'b0;
            op_kind  <= op_stop;
            i2c_done <= 1'b0;
            rd_q     <= 1'b0;
            ctrl_q   <= 1'b0;
        end else begin
            phase    <= next_ph;
            op_go    <= ph_change && (next_ph != ph_idle);
            i2c_done <= (phase == ph_stop) && op_done;
            if (ph_change)
                op_kind <= nxt_kind;
            if (phase == ph_idle && i2c_exec) begin
                rd_q   <= i2c_rh_wl;
                ctrl_q <= bit_ctrl;
            end
        end
    end

    // request payload and outgoing byte
    always_ff @(posedge dri_clk) begin
        if (phase == ph_idle && i2c_exec) begin
            addr_q <= i2c_addr;
            data_q <= i2c_data_w;
        end
        if (ph_change)
            op_byte <= nxt_byte;
    end

endmodule

`default_nettype wire

//--- verilog/i2c_bit_engine.sv
`timescale 1ns/1ns
`default_nettype none

module i2c_bit_engine import i2c_pkg::*; (
    input  logic    dri_clk,
    input  logic    rst_n,

    input  logic    op_go,
    input  bus_op_t op_kind,
    input  byte_t   op_byte,
    output logic    op_done,

    input  logic    sda_in,
    output logic    scl,
    output logic    sda_out,
    output logic    sda_oe,

    output logic    rx_bit_valid,
    output logic    rx_bit,
    output logic    rx_last
);

    logic       busy;
    bit_cnt_t   cnt;
    bus_op_t    kind_q;
    byte_t      byte_q;

    logic       active;
    bus_op_t    cur_kind;
    byte_t      cur_byte;
    logic       is_start;
    logic       last_cyc;
    bit_cnt_t   ofs;                          // offset past the start slot
    logic [1:0] bit_pos;
    logic [2:0] bit_idx;
    logic       in_byte;

    // op_go cycle is cycle 0 of the operation
    assign active   = op_go | busy;
    assign cur_kind = op_go ? op_kind : kind_q;
    assign cur_byte = op_go ? op_byte : byte_q;
    assign is_start = (cur_kind == op_start_byte) || (cur_kind == op_restart_byte);
    assign last_cyc = (cnt == op_len(cur_kind) - 1'b1);

    assign ofs      = is_start ? cnt - bit_cnt_t'(start_len) : cnt;
    assign bit_pos  = ofs[1:0];
    assign bit_idx  = ofs[4:2];
    assign in_byte  = (ofs < bit_cnt_t'(8 * bit_len));

    assign op_done  = busy && last_cyc;

    // sample point is the scl rising offset
    assign rx_bit_valid = active && (cur_kind == op_rx_byte) && in_byte &&
                          (bit_pos == 2'(scl_rise_ofs));
    assign rx_bit       = sda_in;
    assign rx_last      = rx_bit_valid && (bit_idx == 3'd7);

    always_ff @(posedge dri_clk) begin
        if (op_go)
            byte_q <= op_byte;
    end

    // ******************************
    // counter and bus waveform
    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            cnt     <= '0;
            kind_q  <= op_stop;
            scl     <= 1'b1;                  // bus idle high
            sda_out <= 1'b1;
            sda_oe  <= 1'b1;
        end else if (active) begin
            if (op_go)
                kind_q <= op_kind;
            if (last_cyc) begin
                busy <= 1'b0;
                cnt  <= '0;
            end else begin
                busy <= 1'b1;
                cnt  <= cnt + 1'b1;
            end

            if (cur_kind == op_stop) begin
                case (cnt)
                    6'd0: begin
                        sda_oe  <= 1'b1;
                        sda_out <= 1'b0;
                    end
                    6'd1: scl     <= 1'b1;
                    6'd3: sda_out <= 1'b1;    // stop, then hold
                    default: ;
                endcase
            end else if (is_start && cnt < bit_cnt_t'(start_len)) begin
                case (cnt[1:0])
                    2'd0: begin
                        sda_oe  <= 1'b1;
                        sda_out <= 1'b1;
                    end
                    2'd1: scl     <= 1'b1;
                    2'd2: sda_out <= 1'b0;    // sda falls with scl high
                    2'd3: scl     <= 1'b0;
                endcase
            end else if (in_byte) begin
                case (bit_pos)
                    2'(sda_chg_ofs): begin
                        if (cur_kind == op_rx_byte) begin
                            sda_oe <= 1'b0;
                        end else begin
                            sda_oe  <= 1'b1;
                            sda_out <= cur_byte[3'd7 - bit_idx];   // msb first
                        end
                    end
                    2'(scl_rise_ofs): scl <= 1'b1;
                    2'(scl_fall_ofs): scl <= 1'b0;
                    default: ;
                endcase
            end else begin
                // ack slot
                case (bit_pos)
                    2'(sda_chg_ofs): begin
                        sda_oe  <= (cur_kind == op_rx_byte);   // nack after rx
                        sda_out <= 1'b1;
                    end
                    2'(scl_rise_ofs): scl <= 1'b1;
                    2'(scl_fall_ofs): scl <= 1'b0;
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/i2c_read_capture.sv
`timescale 1ns/1ns
`default_nettype none

module i2c_read_capture import i2c_pkg::*; (
    input  logic  dri_clk,
    input  logic  rst_n,

    input  logic  rx_bit_valid,
    input  logic  rx_bit,
    input  logic  rx_last,

    output byte_t i2c_data_r
);

    // seven earlier bits; the eighth comes in with rx_last
    logic [6:0] shift_q;
    byte_t      full_byte;

    assign full_byte = {shift_q, rx_bit};

    // ******************************
    // bit assembly, msb first
    always_ff @(posedge dri_clk) begin
        if (rx_bit_valid)
            shift_q <= full_byte[6:0];
    end

    // read byte register
    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n)
            i2c_data_r <= '0;
        else if (rx_last)
            i2c_data_r <= full_byte;          // held until next read
    end

endmodule

`default_nettype wire

//--- verilog/i2c_master.sv
`timescale 1ns/1ns
`default_nettype none

module i2c_master import i2c_pkg::*; #(
    parameter dev_addr_t SLAVE_ADDR = 7'h10
) (
    input  logic      dri_clk,
    input  logic      rst_n,

    input  logic      i2c_exec,
    input  logic      bit_ctrl,               // 1: 16-bit word address
    input  logic      i2c_rh_wl,              // 1: read
    input  mem_addr_t i2c_addr,
    input  byte_t     i2c_data_w,

    output byte_t     i2c_data_r,
    output logic      i2c_done,

    output logic      scl,
    inout  wire       sda
);

    logic    op_go;
    bus_op_t op_kind;
    byte_t   op_byte;
    logic    op_done;
    logic    sda_out;
    logic    sda_oe;
    logic    sda_in;
    logic    rx_bit_valid;
    logic    rx_bit;
    logic    rx_last;

    // ******************************
    // open-drain style pad
    assign sda    = sda_oe ? sda_out : 1'bz;
    assign sda_in = sda;

    i2c_phase_seq #(
        .SLAVE_ADDR (SLAVE_ADDR)
    ) i2c_phase_seq_i (
        .dri_clk    (dri_clk),
        .rst_n      (rst_n),
        .i2c_exec   (i2c_exec),
        .bit_ctrl   (bit_ctrl),
        .i2c_rh_wl  (i2c_rh_wl),
        .i2c_addr   (i2c_addr),
        .i2c_data_w (i2c_data_w),
        .op_done    (op_done),
        .op_go      (op_go),
        .op_kind    (op_kind),
        .op_byte    (op_byte),
        .i2c_done   (i2c_done)
    );

    i2c_bit_engine i2c_bit_engine_i (
        .dri_clk      (dri_clk),
        .rst_n        (rst_n),
        .op_go        (op_go),
        .op_kind      (op_kind),
        .op_byte      (op_byte),
        .op_done      (op_done),
        .sda_in       (sda_in),
        .scl          (scl),
        .sda_out      (sda_out),
        .sda_oe       (sda_oe),
        .rx_bit_valid (rx_bit_valid),
        .rx_bit       (rx_bit),
        .rx_last      (rx_last)
    );

    i2c_read_capture i2c_read_capture_i (
        .dri_clk      (dri_clk),
        .rst_n        (rst_n),
        .rx_bit_valid (rx_bit_valid),
        .rx_bit       (rx_bit),
        .rx_last      (rx_last),
        .i2c_data_r   (i2c_data_r)
    );

endmodule

`default_nettype wire

//--- tb/i2c_slave_model.sv
`timescale 1ns/1ns
`default_nettype none

module i2c_slave_model #(
    parameter logic [6:0] DEV_ADDR = 7'h10
) (
    input  wire scl,
    inout  wire sda
);

    logic [7:0]  mem [0:65535];
    logic        drive_low;
    logic        in_frame;
    logic        reading;
    logic        rd_pending;                  // read bit seen, data after ack
    logic        acked;
    int          bit_cnt;
    int          byte_idx;
    logic [7:0]  shreg;
    logic [7:0]  rx_q [$];
    logic [15:0] ptr;

    // what the last frame looked like
    logic [7:0]  dev_w_byte;
    logic [7:0]  dev_r_byte;
    int          addr_len;
    logic        restarted;
    logic        nacked;
    logic        addr_err;
    logic [15:0] wr_addr;
    logic [15:0] rd_addr;
    int          wr_count;
    int          stop_count;

    assign sda = drive_low ? 1'b0 : 1'bz;

    function automatic logic [15:0] addr_from_queue(input int n);
        if (n == 2)
            return {rx_q[0], rx_q[1]};
        return {8'h00, rx_q[0]};
    endfunction

    initial begin
        for (int i = 0; i < 65536; i++)
            mem[i] = 8'hff;                   // never written reads as ff
        drive_low  = 1'b0;
        in_frame   = 1'b0;
        reading    = 1'b0;
        rd_pending = 1'b0;
        acked      = 1'b0;
        bit_cnt    = 0;
        byte_idx   = 0;
        addr_err   = 1'b0;
        wr_count   = 0;
        stop_count = 0;
    end

    // ******************************
    // start, repeated start, stop
    always @(negedge sda) begin
        if (scl === 1'b1) begin
            if (in_frame) begin
                restarted = 1'b1;
                addr_len  = rx_q.size();
                ptr       = addr_from_queue(rx_q.size());
                rd_addr   = ptr;
            end else begin
                restarted  = 1'b0;
                nacked     = 1'b0;
                addr_len   = 0;
                dev_w_byte = 8'h00;
                dev_r_byte = 8'h00;
            end
            in_frame   = 1'b1;
            reading    = 1'b0;
            rd_pending = 1'b0;
            acked      = 1'b0;
            bit_cnt    = 0;
            byte_idx   = 0;
            rx_q.delete();
        end
    end

    always @(posedge sda) begin
        if (scl === 1'b1 && in_frame) begin
            if (!reading && rx_q.size() >= 2) begin   // last byte is the data
                addr_len = rx_q.size() - 1;
                wr_addr  = addr_from_queue(rx_q.size() - 1);
                mem[wr_addr] = rx_q[rx_q.size() - 1];
                wr_count++;
            end
            stop_count++;
            in_frame = 1'b0;
            reading  = 1'b0;
        end
    end

    // ******************************
    // bit level
    always @(posedge scl) begin
        if (in_frame) begin
            if (!reading && bit_cnt < 8) begin
                shreg = {shreg[6:0], sda === 1'b1};
                bit_cnt++;
            end else if (reading && bit_cnt < 8) begin
                bit_cnt++;
            end else if (reading && bit_cnt == 8) begin
                nacked = (sda === 1'b1);      // master ends the read
                bit_cnt++;
            end
        end
    end

    // changes wait until the master has let go of sda
    always @(negedge scl) begin
        if (in_frame) begin
            drive_low = 1'b0;
            if (!reading && bit_cnt == 8 && !acked) begin
                acked = 1'b1;
                if (byte_idx == 0) begin
                    if (shreg[7:1] != DEV_ADDR)
                        addr_err = 1'b1;
                    else if (shreg[0]) begin
                        dev_r_byte = shreg;
                        rd_pending = 1'b1;
                    end else
                        dev_w_byte = shreg;
                end else
                    rx_q.push_back(shreg);
                byte_idx++;
                if (shreg[7:1] == DEV_ADDR || byte_idx > 1)
                    #6 drive_low = 1'b1;      // ack
            end else if (!reading && bit_cnt == 8) begin
                acked   = 1'b0;
                bit_cnt = 0;
                if (rd_pending) begin
                    rd_pending = 1'b0;
                    reading    = 1'b1;
                    shreg      = mem[ptr];
                    #6 drive_low = !shreg[7];
                end
            end else if (reading && bit_cnt < 8) begin
                #6 drive_low = !shreg[7 - bit_cnt];
            end
        end
    end

endmodule

`default_nettype wire

//--- tb/tb_i2c_master.sv
`timescale 1ns/1ns
`default_nettype none

module tb_i2c_master import i2c_pkg::*; ;

    localparam int n_trans     = 40;
    localparam int cycle_limit = n_trans * 260 + 200;

    logic      dri_clk = 1'b0;
    logic      rst_n;
    logic      i2c_exec;
    logic      bit_ctrl;
    logic      i2c_rh_wl;
    mem_addr_t i2c_addr;
    byte_t     i2c_data_w;
    byte_t     i2c_data_r;
    logic      i2c_done;
    logic      scl;
    wire       sda;

    logic [31:0] lcg_state = 32'h734df83d;
    byte_t       ref_mem [0:65535];
    mem_addr_t   addr_pool [0:7];             // small pool so reads hit writes
    int          done_count = 0;
    int          cycles = 0;
    logic        done_q = 1'b0;

    pullup (sda);

    always #2 dri_clk = ~dri_clk;

    i2c_master i2c_master_i (
        .dri_clk    (dri_clk),
        .rst_n      (rst_n),
        .i2c_exec   (i2c_exec),
        .bit_ctrl   (bit_ctrl),
        .i2c_rh_wl  (i2c_rh_wl),
        .i2c_addr   (i2c_addr),
        .i2c_data_w (i2c_data_w),
        .i2c_data_r (i2c_data_r),
        .i2c_done   (i2c_done),
        .scl        (scl),
        .sda        (sda)
    );

    i2c_slave_model #(.DEV_ADDR(7'h10)) slave_i (.scl(scl), .sda(sda));

    function logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task stop_on_error(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task check_equal(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (exp == act)
        else stop_on_error($sformatf("ERROR %s expected %0h actual %0h", name, exp, act));
    endtask

    // ******************************
    // done pulse monitor and timeout
    always @(posedge dri_clk) begin
        cycles++;
        if (i2c_done)
            done_count++;
        assert (!(i2c_done && done_q))
        else stop_on_error("i2c_done stayed high for more than one cycle");
        done_q = i2c_done;
        assert (cycles < cycle_limit)
        else stop_on_error("timeout: i2c_done never came");
    end

    task run_one();
        logic [31:0] r;
        logic        rd;
        logic        wide;
        logic        extra;
        mem_addr_t   addr;
        mem_addr_t   eff;
        byte_t       data;
        int          idle;
        int          done_before;
        int          wr_before;
        int          stop_before;
        r     = next_rand();
        rd    = r[17];
        wide  = r[21];
        extra = r[29];
        addr  = addr_pool[r[26:24]];
        r     = next_rand();
        data  = r[23:16];
        idle  = r[27:25];
        eff   = wide ? addr : {8'h00, addr[7:0]};   // high byte not sent
        done_before = done_count;
        wr_before   = slave_i.wr_count;
        stop_before = slave_i.stop_count;

        @(posedge dri_clk);
        i2c_exec   <= 1'b1;
        bit_ctrl   <= wide;
        i2c_rh_wl  <= rd;
        i2c_addr   <= addr;
        i2c_data_w <= data;
        @(posedge dri_clk);
        i2c_exec   <= 1'b0;
        if (extra) begin
            repeat (30) @(posedge dri_clk);
            i2c_exec   <= 1'b1;               // must be dropped
            i2c_rh_wl  <= 1'b0;
            i2c_addr   <= ~addr;
            i2c_data_w <= ~data;
            @(posedge dri_clk);
            i2c_exec   <= 1'b0;
        end
        while (!i2c_done)
            @(posedge dri_clk);
        repeat (idle + 2) @(posedge dri_clk);

        if (!rd)
            ref_mem[eff] = data;
        check_equal("done_count", done_before + 1, done_count);
        check_equal("stop_count", stop_before + 1, slave_i.stop_count);
        check_equal("dev_write_byte", 8'h20, slave_i.dev_w_byte);
        check_equal("addr_bytes", wide ? 2 : 1, slave_i.addr_len);
        check_equal("dev_addr_match", 0, slave_i.addr_err);
        if (rd) begin
            check_equal("restart_seen", 1, slave_i.restarted);
            check_equal("dev_read_byte", 8'h21, slave_i.dev_r_byte);
            check_equal("read_nack", 1, slave_i.nacked);
            check_equal("read_addr", eff, slave_i.rd_addr);
            check_equal("read_data", ref_mem[eff], i2c_data_r);
            check_equal("write_count", wr_before, slave_i.wr_count);
        end else begin
            check_equal("write_addr", eff, slave_i.wr_addr);
            check_equal("write_count", wr_before + 1, slave_i.wr_count);
            check_equal("write_data", ref_mem[eff], slave_i.mem[eff]);
        end
    endtask

    // ******************************
    initial begin
        logic [31:0] r;
        for (int i = 0; i < 65536; i++)
            ref_mem[i] = 8'hff;
        for (int i = 0; i < 8; i++) begin
            r = next_rand();
            addr_pool[i] = r[31:16];
        end
        rst_n      = 1'b0;
        i2c_exec   = 1'b0;
        bit_ctrl   = 1'b0;
        i2c_rh_wl  = 1'b0;
        i2c_addr   = '0;
        i2c_data_w = '0;

        repeat (2) @(posedge dri_clk);
        check_equal("reset_scl", 1, scl);
        check_equal("reset_sda", 1, sda);
        check_equal("reset_done", 0, i2c_done);
        rst_n <= 1'b1;
        repeat (3) @(posedge dri_clk);
        check_equal("idle_scl", 1, scl);
        check_equal("idle_sda", 1, sda);
        check_equal("idle_done", 0, done_count);

        for (int t = 0; t < n_trans; t++)
            run_one();

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
verilog/i2c_pkg.sv
verilog/i2c_phase_seq.sv
verilog/i2c_bit_engine.sv
verilog/i2c_read_capture.sv
verilog/i2c_master.sv
tb/i2c_slave_model.sv
tb/tb_i2c_master.sv

//--- Bender.yml
package:
  name: i2c_master

sources:
  - files:
      - verilog/i2c_pkg.sv
      - verilog/i2c_phase_seq.sv
      - verilog/i2c_bit_engine.sv
      - verilog/i2c_read_capture.sv
      - verilog/i2c_master.sv
  - target: test
    files:
      - tb/i2c_slave_model.sv
      - tb/tb_i2c_master.sv
